/* src/xt_bus_pkg.sv */
//------------------------------------------------
// XT bus definitions
// CPU bus widths, port groups, PPI register
// offsets and the structs that carry bus traffic
//------------------------------------------------
package xt_bus_pkg;

    localparam int data_width_c     = 8;
    localparam int addr_width_c     = 20;
    localparam int io_group_count_c = 8;

    // Port groups, taken from address bits 7 to 5
    localparam logic [2:0] group_dma_c      = 3'd0;
    localparam logic [2:0] group_pic_c      = 3'd1;
    localparam logic [2:0] group_pit_c      = 3'd2;
    localparam logic [2:0] group_ppi_c      = 3'd3;
    localparam logic [2:0] group_dma_page_c = 3'd4;

    // PPI register offsets, address bits 1 and 0
    localparam logic [1:0] ppi_port_a_c = 2'd0;
    localparam logic [1:0] ppi_port_b_c = 2'd1;
    localparam logic [1:0] ppi_port_c_c = 2'd2;

    // CPU side of one I/O cycle
    typedef struct packed {
        logic [addr_width_c-1:0] address;
        logic [data_width_c-1:0] wdata;
        logic                    io_read_n;
        logic                    io_write_n;
        logic                    aen_n;
    } io_bus_t;

    // Decoded PPI access, strobes active high
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [1:0]              reg_sel;
        logic [data_width_c-1:0] wdata;
    } ppi_access_t;

endpackage

/* src/ps2_kbd_pkg.sv */
//------------------------------------------------
// PS/2 keyboard definitions
// Frame layout, frame timeout, scan code and
// port B bit assignment
//------------------------------------------------
package ps2_kbd_pkg;

    // Start, eight data bits LSB first, parity, stop
    localparam int frame_bits_c = 11;
    localparam int start_bit_c  = 0;
    localparam int data_lsb_c   = 1;
    localparam int data_msb_c   = 8;
    localparam int parity_bit_c = 9;
    localparam int stop_bit_c   = 10;

    // Idle cycles before a partial frame is dropped
    localparam int ps2_timeout_c = 1000;

    typedef logic [$clog2(frame_bits_c)-1:0]    bit_count_t;
    typedef logic [$clog2(ps2_timeout_c+1)-1:0] timeout_t;

    localparam bit_count_t last_bit_c      = bit_count_t'(frame_bits_c - 1);
    localparam timeout_t   timeout_limit_c = timeout_t'(ps2_timeout_c);

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } scan_t;

    // Bit 7 clears and holds off the key-code latch
    typedef struct packed {
        logic       kbd_clear;
        logic [6:0] spare;
    } port_b_t;

endpackage

/* src/ps2_receiver.sv */
//------------------------------------------------
// PS/2 receiver
// Synchronizes the PS/2 lines and assembles
// 11-bit frames, passing on checked scan codes
//------------------------------------------------
`timescale 1ns/1ps

module ps2_receiver (
    input  logic               clock,
    input  logic               reset,
    input  logic               ps2_clock_i,
    input  logic               ps2_data_i,
    output ps2_kbd_pkg::scan_t scan_o
);

    logic                                   ps2_clock_meta;
    logic                                   ps2_clock_sync;
    logic                                   ps2_clock_prev;
    logic                                   ps2_data_meta;
    logic                                   ps2_data_sync;
    logic                                   falling_edge;
    ps2_kbd_pkg::bit_count_t                bit_count;
    ps2_kbd_pkg::timeout_t                  idle_count;
    logic [ps2_kbd_pkg::frame_bits_c-2:0]   shift_reg;
    logic [ps2_kbd_pkg::frame_bits_c-1:0]   frame_next;
    logic                                   frame_done;
    logic                                   frame_good;
    logic                                   scan_valid;
    logic [7:0]                             scan_code;

    // Two-flop synchronizers, both lines idle high
    always_ff @(posedge clock) begin
        if (reset) begin
            ps2_clock_meta <= 1'b1;
            ps2_clock_sync <= 1'b1;
            ps2_clock_prev <= 1'b1;
            ps2_data_meta  <= 1'b1;
            ps2_data_sync  <= 1'b1;
        end
        else begin
            ps2_clock_meta <= ps2_clock_i;
            ps2_clock_sync <= ps2_clock_meta;
            ps2_clock_prev <= ps2_clock_sync;
            ps2_data_meta  <= ps2_data_i;
            ps2_data_sync  <= ps2_data_meta;
        end
    end

    assign falling_edge = ps2_clock_prev & ~ps2_clock_sync;

    // Bits arrive LSB first, so new data enters at the top
    assign frame_next = {ps2_data_sync, shift_reg};
    assign frame_done = falling_edge && (bit_count == ps2_kbd_pkg::last_bit_c);

    // Odd parity over data and parity bit
    assign frame_good = ~frame_next[ps2_kbd_pkg::start_bit_c]
                      & frame_next[ps2_kbd_pkg::stop_bit_c]
                      & (^frame_next[ps2_kbd_pkg::parity_bit_c:ps2_kbd_pkg::data_lsb_c]);

    always_ff @(posedge clock) begin
        if (falling_edge) begin
            shift_reg <= frame_next[ps2_kbd_pkg::frame_bits_c-1:1];
        end
    end

    // Bit count and idle timer
    always_ff @(posedge clock) begin
        if (reset) begin
            bit_count  <= '0;
            idle_count <= '0;
        end
        else if (falling_edge) begin
            idle_count <= '0;
            if (frame_done) begin
                bit_count <= '0;
            end
            else begin
                bit_count <= bit_count + 1'b1;
            end
        end
        else if (idle_count == ps2_kbd_pkg::timeout_limit_c) begin
            // Line stalled mid-frame, start over
            bit_count <= '0;
        end
        else begin
            idle_count <= idle_count + 1'b1;
        end
    end

    // One-cycle pulse per accepted frame
    always_ff @(posedge clock) begin
        if (reset) begin
            scan_valid <= 1'b0;
        end
        else begin
            scan_valid <= frame_done & frame_good;
        end
    end

    always_ff @(posedge clock) begin
        if (frame_done) begin
            scan_code <= frame_next[ps2_kbd_pkg::data_msb_c:ps2_kbd_pkg::data_lsb_c];
        end
    end

    assign scan_o.valid = scan_valid;
    assign scan_o.code  = scan_code;

endmodule

/* src/xt_ppi.sv */
//------------------------------------------------
// XT 8255 port model
// Port B output register, key-code latch on
// port A and the keyboard interrupt
//------------------------------------------------
`timescale 1ns/1ps

module xt_ppi (
    input  logic                                clock,
    input  logic                                reset,
    input  ps2_kbd_pkg::scan_t                  scan_i,
    input  xt_bus_pkg::ppi_access_t             access_i,
    input  logic [xt_bus_pkg::data_width_c-1:0] port_c_i,
    output logic [xt_bus_pkg::data_width_c-1:0] rdata_o,
    output ps2_kbd_pkg::port_b_t                port_b_out_o,
    output logic                                keyboard_irq_o
);

    ps2_kbd_pkg::port_b_t                port_b_reg;
    logic [xt_bus_pkg::data_width_c-1:0] key_code;
    logic                                key_irq;
    logic                                port_b_write;
    logic                                key_accept;

    // Ports A and C are inputs on the XT, only B takes writes
    assign port_b_write = access_i.wr && (access_i.reg_sel == xt_bus_pkg::ppi_port_b_c);

    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_reg <= '0;
        end
        else if (port_b_write) begin
            port_b_reg <= ps2_kbd_pkg::port_b_t'(access_i.wdata);
        end
    end

    // New code only when nothing is held and the latch is released
    assign key_accept = scan_i.valid & ~key_irq & ~port_b_reg.kbd_clear;

    always_ff @(posedge clock) begin
        if (reset) begin
            key_code <= '0;
            key_irq  <= 1'b0;
        end
        else if (port_b_reg.kbd_clear) begin
            // Software acknowledge empties the latch
            key_code <= '0;
            key_irq  <= 1'b0;
        end
        else if (key_accept) begin
            key_code <= scan_i.code;
            key_irq  <= 1'b1;
        end
    end

    // Register read mux
    always_comb begin
        rdata_o = '0;
        if (access_i.rd) begin
            case (access_i.reg_sel)
                xt_bus_pkg::ppi_port_a_c: rdata_o = key_code;
                xt_bus_pkg::ppi_port_b_c: rdata_o = port_b_reg;
                xt_bus_pkg::ppi_port_c_c: rdata_o = port_c_i;
                default:                  rdata_o = '0;
            endcase
        end
    end

    assign port_b_out_o   = port_b_reg;
    assign keyboard_irq_o = key_irq;

endmodule

/* src/xt_io_bus.sv */
//------------------------------------------------
// XT I/O bus
// Port-group decode, PPI strobes and the CPU
// read-data drive
//------------------------------------------------
`timescale 1ns/1ps

module xt_io_bus (
    input  xt_bus_pkg::io_bus_t                     io_bus_i,
    input  logic [xt_bus_pkg::data_width_c-1:0]     ppi_rdata_i,
    output logic [xt_bus_pkg::io_group_count_c-1:0] io_select_n_o,
    output xt_bus_pkg::ppi_access_t                 ppi_access_o,
    output logic [xt_bus_pkg::data_width_c-1:0]     data_bus_out_o,
    output logic                                    data_bus_out_from_chipset_o
);

    logic       ppi_select;
    logic       ppi_read;
    logic       ppi_readable;
    logic [1:0] reg_sel;

    // Groups live in 000-0FF, 32 ports each, only with AEN inactive
    always_comb begin
        io_select_n_o = '1;
        if (~io_bus_i.aen_n && (io_bus_i.address[9:8] == 2'b00)) begin
            io_select_n_o[io_bus_i.address[7:5]] = 1'b0;
        end
    end

    assign ppi_select = ~io_select_n_o[xt_bus_pkg::group_ppi_c];
    assign reg_sel    = io_bus_i.address[1:0];
    assign ppi_read   = ppi_select & ~io_bus_i.io_read_n;

    assign ppi_access_o.rd      = ppi_read;
    assign ppi_access_o.wr      = ppi_select & ~io_bus_i.io_write_n;
    assign ppi_access_o.reg_sel = reg_sel;
    assign ppi_access_o.wdata   = io_bus_i.wdata;

    // Offset 3 is the control word, which reads back nothing here
    assign ppi_readable = (reg_sel == xt_bus_pkg::ppi_port_a_c)
                        | (reg_sel == xt_bus_pkg::ppi_port_b_c)
                        | (reg_sel == xt_bus_pkg::ppi_port_c_c);

    always_comb begin
        if (ppi_read && ppi_readable) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = ppi_rdata_i;
        end
        else begin
            data_bus_out_from_chipset_o = 1'b0;
            data_bus_out_o              = '0;
        end
    end

endmodule

/* src/xt_keyboard_io.sv */
//------------------------------------------------
// XT keyboard and I/O port block
// PS/2 receiver, PPI and I/O bus decode
//------------------------------------------------
`timescale 1ns/1ps

module xt_keyboard_io (
    input  logic                                    clock,
    input  logic                                    reset,
    input  xt_bus_pkg::io_bus_t                     io_bus_i,
    input  logic                                    ps2_clock_i,
    input  logic                                    ps2_data_i,
    input  logic [xt_bus_pkg::data_width_c-1:0]     port_c_i,
    output logic [xt_bus_pkg::io_group_count_c-1:0] io_select_n_o,
    output logic [xt_bus_pkg::data_width_c-1:0]     data_bus_out_o,
    output logic                                    data_bus_out_from_chipset_o,
    output ps2_kbd_pkg::port_b_t                    port_b_out_o,
    output logic                                    keyboard_irq_o
);

    ps2_kbd_pkg::scan_t                  scan;
    xt_bus_pkg::ppi_access_t             ppi_access;
    logic [xt_bus_pkg::data_width_c-1:0] ppi_rdata;

    ps2_receiver ps2_receiver_inst (
        .clock       (clock),
        .reset       (reset),
        .ps2_clock_i (ps2_clock_i),
        .ps2_data_i  (ps2_data_i),
        .scan_o      (scan)
    );

    xt_ppi xt_ppi_inst (
        .clock          (clock),
        .reset          (reset),
        .scan_i         (scan),
        .access_i       (ppi_access),
        .port_c_i       (port_c_i),
        .rdata_o        (ppi_rdata),
        .port_b_out_o   (port_b_out_o),
        .keyboard_irq_o (keyboard_irq_o)
    );

    // Read data comes back combinationally from the PPI
    xt_io_bus xt_io_bus_inst (
        .io_bus_i                    (io_bus_i),
        .ppi_rdata_i                 (ppi_rdata),
        .io_select_n_o               (io_select_n_o),
        .ppi_access_o                (ppi_access),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* testbench/tb_xt_keyboard_io.sv */
//------------------------------------------------
// Testbench for the XT keyboard and I/O block
// Runs the tests listed in the tests file
//------------------------------------------------
`timescale 1ns/1ps

module tb_xt_keyboard_io;

    localparam int          clk_period_c   = 4;
    localparam int          ps2_half_c     = 20;
    localparam int          frame_cycles_c = ps2_kbd_pkg::frame_bits_c * 2 * ps2_half_c;
    // Expected-data value in the file that stands for the driven port C input
    localparam logic [31:0] port_c_token_c = 32'h100;

    logic                                    clock;
    logic                                    reset;
    xt_bus_pkg::io_bus_t                     io_bus;
    logic                                    ps2_clock;
    logic                                    ps2_data;
    logic [xt_bus_pkg::data_width_c-1:0]     port_c;
    logic [xt_bus_pkg::io_group_count_c-1:0] io_select_n;
    logic [xt_bus_pkg::data_width_c-1:0]     data_bus_out;
    logic                                    data_bus_out_from_chipset;
    ps2_kbd_pkg::port_b_t                    port_b_out;
    logic                                    keyboard_irq;

    string       name_q[$];
    string       op_q[$];
    logic [31:0] arg_a_q[$];
    logic [31:0] arg_b_q[$];
    logic [31:0] expect_q[$];
    logic [31:0] lcg_state;
    logic        tests_loaded;
    int          test_errors;
    int          failed_count;
    int          format_errors;

    xt_keyboard_io xt_keyboard_io_inst (
        .clock                       (clock),
        .reset                       (reset),
        .io_bus_i                    (io_bus),
        .ps2_clock_i                 (ps2_clock),
        .ps2_data_i                  (ps2_data),
        .port_c_i                    (port_c),
        .io_select_n_o               (io_select_n),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset),
        .port_b_out_o                (port_b_out),
        .keyboard_irq_o              (keyboard_irq)
    );

    always #(clk_period_c / 2) clock = ~clock;

    function logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    // Inputs move 1 ns after the rising edge
    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(posedge clock);
        #1;
    endtask

    task automatic bus_idle();
        io_bus.address    = '0;
        io_bus.wdata      = '0;
        io_bus.io_read_n  = 1'b1;
        io_bus.io_write_n = 1'b1;
        io_bus.aen_n      = 1'b1;
    endtask

    task automatic write_port(input string name, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] expected);
        logic [7:0] actual;
        wait_cycles(1);
        io_bus.address    = addr[19:0];
        io_bus.wdata      = data[7:0];
        io_bus.io_write_n = 1'b0;
        io_bus.aen_n      = 1'b0;
        wait_cycles(1);
        bus_idle();
        @(negedge clock);
        actual = port_b_out;
        assert (actual == expected[7:0]) else begin
            $display("[ERROR] %s: port B expected %h, actual %h", name, expected[7:0], actual);
            test_errors++;
        end
    endtask

    task automatic read_port(input string name, input logic [31:0] addr,
                             input logic [31:0] exp_chipset, input logic [31:0] expected);
        logic [7:0] exp_data;
        wait_cycles(1);
        port_c   = lcg_next();
        exp_data = (expected == port_c_token_c) ? port_c : expected[7:0];
        io_bus.address   = addr[19:0];
        io_bus.io_read_n = 1'b0;
        io_bus.aen_n     = 1'b0;
        @(negedge clock);
        assert (data_bus_out_from_chipset == exp_chipset[0]) else begin
            $display("[ERROR] %s: from_chipset expected %h, actual %h",
                     name, exp_chipset[0], data_bus_out_from_chipset);
            test_errors++;
        end
        assert (data_bus_out == exp_data) else begin
            $display("[ERROR] %s: read data expected %h, actual %h", name, exp_data, data_bus_out);
            test_errors++;
        end
        wait_cycles(1);
        bus_idle();
    endtask

    task automatic check_select(input string name, input logic [31:0] addr,
                                input logic [31:0] aen, input logic [31:0] expected);
        wait_cycles(1);
        io_bus.address = addr[19:0];
        io_bus.aen_n   = aen[0];
        @(negedge clock);
        assert (io_select_n == expected[7:0]) else begin
            $display("[ERROR] %s: selects expected %h, actual %h", name, expected[7:0], io_select_n);
            test_errors++;
        end
        wait_cycles(1);
        bus_idle();
    endtask

    // Data changes while the PS/2 clock is high, LSB of the frame first
    task automatic send_ps2_bits(input logic [10:0] frame, input int count);
        for (int i = 0; i < count; i++) begin
            ps2_data = frame[i];
            wait_cycles(ps2_half_c);
            ps2_clock = 1'b0;
            wait_cycles(ps2_half_c);
            ps2_clock = 1'b1;
        end
        wait_cycles(ps2_half_c);
        ps2_data = 1'b1;
    endtask

    task automatic send_frame(input logic [7:0] code, input logic good);
        logic parity;
        parity = good ? ~^code : ^code;
        send_ps2_bits({1'b1, parity, code, 1'b0}, ps2_kbd_pkg::frame_bits_c);
    endtask

    // Start bit and a few ones, then a stall past the timeout
    task automatic send_partial(input int count);
        send_ps2_bits(11'h7fe, count);
        wait_cycles(ps2_kbd_pkg::ps2_timeout_c + 2 * ps2_half_c);
    endtask

    task automatic wait_irq(input string name, input logic [31:0] cycles,
                            input logic [31:0] expected);
        wait_cycles(int'(cycles));
        @(negedge clock);
        assert (keyboard_irq == expected[0]) else begin
            $display("[ERROR] %s: keyboard IRQ expected %h, actual %h",
                     name, expected[0], keyboard_irq);
            test_errors++;
        end
    endtask

    task automatic run_test(input int idx);
        string       name;
        string       op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] expected;
        name     = name_q[idx];
        op       = op_q[idx];
        arg_a    = arg_a_q[idx];
        arg_b    = arg_b_q[idx];
        expected = expect_q[idx];
        if (op == "W") begin
            write_port(name, arg_a, arg_b, expected);
        end
        else if (op == "R") begin
            read_port(name, arg_a, arg_b, expected);
        end
        else if (op == "K") begin
            send_frame(arg_a[7:0], arg_b[0]);
        end
        else if (op == "P") begin
            send_partial(int'(arg_a));
        end
        else if (op == "Q") begin
            wait_irq(name, arg_a, expected);
        end
        else if (op == "S") begin
            check_select(name, arg_a, arg_b, expected);
        end
        else begin
            $display("%s: unknown operation %s in the tests file", name, op);
            test_errors++;
        end
    endtask

    initial begin
        string       line;
        string       name;
        string       op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] expected;
        int          fd;
        int          count;
        clock         = 1'b0;
        reset         = 1'b1;
        bus_idle();
        ps2_clock     = 1'b1;
        ps2_data      = 1'b1;
        port_c        = '0;
        lcg_state     = 32'h0b0bf7be;
        tests_loaded  = 1'b0;
        test_errors   = 0;
        failed_count  = 0;
        format_errors = 0;

        fd = $fopen("testbench/xt_keyboard_io_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file");
            format_errors++;
        end
        else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                count = $sscanf(line, "%s %s %h %h %h", name, op, arg_a, arg_b, expected);
                if (count != 5) begin
                    $display("malformed line in the tests file: %s", line);
                    format_errors++;
                end
                else begin
                    name_q.push_back(name);
                    op_q.push_back(op);
                    arg_a_q.push_back(arg_a);
                    arg_b_q.push_back(arg_b);
                    expect_q.push_back(expected);
                end
            end
            $fclose(fd);
        end
        if (name_q.size() == 0) begin
            $display("no tests were loaded");
            format_errors++;
        end
        tests_loaded = 1'b1;

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int idx = 0; idx < name_q.size(); idx++) begin
            test_errors = 0;
            run_test(idx);
            if (test_errors == 0) begin
                $display("test %s passed", name_q[idx]);
            end
            else begin
                $display("test %s failed with %0d errors", name_q[idx], test_errors);
                failed_count++;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 name_q.size(), name_q.size() - failed_count, failed_count);
        if (failed_count == 0 && format_errors == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Budget of 25 PS/2 frame times per test, plus the reset
    initial begin
        int limit_ns;
        wait (tests_loaded == 1'b1);
        limit_ns = (name_q.size() * 25 * frame_cycles_c + 100) * clk_period_c;
        #(limit_ns);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* testbench/xt_keyboard_io_tests.txt */
# name op arg_a arg_b expected, numbers in hex
# W addr data port_b | R addr chipset data (100 = port C input) | K code good 0 | P bits 0 0 | Q cycles 0 irq | S addr aen_n selects
sel_dma S 000 0 fe
sel_pic S 020 0 fd
sel_pit S 040 0 fb
sel_ppi S 060 0 f7
sel_page S 080 0 ef
sel_grp5 S 0a0 0 df
sel_grp6 S 0c0 0 bf
sel_grp7 S 0e0 0 7f
sel_aen S 060 1 ff
sel_a8 S 160 0 ff
sel_a9 S 260 0 ff
wr_pb W 061 5a 5a
rd_pb R 061 1 5a
rd_ctl R 063 0 00
rd_unsel R 021 0 00
rd_pc R 062 1 100
key_first K 1c 1 0
irq_set Q 8 0 1
rd_key R 060 1 1c
key_second K 32 1 0
rd_held R 060 1 1c
clr_set W 061 80 80
irq_clr Q 2 0 0
rd_clr R 060 1 00
clr_rel W 061 00 00
key_new K 21 1 0
rd_new R 060 1 21
ack_set W 061 80 80
ack_rel W 061 00 00
bad_par K 45 0 0
irq_bad Q 8 0 0
partial P 5 0 0
key_good K 3b 1 0
irq_good Q 8 0 1
rd_good R 060 1 3b

/* xt_keyboard_io.f */
src/xt_bus_pkg.sv
src/ps2_kbd_pkg.sv
src/ps2_receiver.sv
src/xt_ppi.sv
src/xt_io_bus.sv
src/xt_keyboard_io.sv
testbench/tb_xt_keyboard_io.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_xt_keyboard_io \
    -f xt_keyboard_io.f -o sim_xt_keyboard_io > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_xt_keyboard_io > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
